//--- hwlp_loop_ctrl.sv
// Hardware-loop controller
// Watches the fetch PC against every slot end address and requests a jump
// back to the loop start; decrements the winning slot when fetch advances

`timescale 1ns/1ps

module hwlp_loop_ctrl (
  input  logic [hwlp_pkg::XLEN-1:0]                              pc_if_i,
  input  logic                                                   fetch_advance_i,
  input  logic [hwlp_pkg::HWLP_N_SLOTS-1:0][hwlp_pkg::XLEN-1:0] start_i,
  input  logic [hwlp_pkg::HWLP_N_SLOTS-1:0][hwlp_pkg::XLEN-1:0] end_i,
  input  logic [hwlp_pkg::HWLP_N_SLOTS-1:0][hwlp_pkg::XLEN-1:0] counter_i,
  output logic [hwlp_pkg::HWLP_N_SLOTS-1:0]                      dec_o,
  output logic                                                   hwlp_jump_o,
  output logic [hwlp_pkg::XLEN-1:0]                              hwlp_targ_addr_o
);

  import hwlp_pkg::*;

  logic [HWLP_N_SLOTS-1:0]   active;
  logic [HWLP_N_SLOTS-1:0]   match;
  logic [HWLP_N_SLOTS-1:0]   win_oh;
  logic [HWLP_SLOT_BITS-1:0] win_idx;
  logic                      hit;
  logic [XLEN-1:0]           win_cnt;
  logic [XLEN-1:0]           win_start;

  ////////////////////////////////////////
  // End address compare
  ////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < HWLP_N_SLOTS; i++)
    begin
      // Slot live while counter nonzero
      active[i] = (counter_i[i] != '0);
      match[i]  = active[i] && (end_i[i] == pc_if_i);
    end
  end

  ////////////////////////////////////////
  // Priority select, lowest index wins
  ////////////////////////////////////////

  always_comb
  begin
    hit     = 1'b0;
    win_idx = '0;
    win_oh  = '0;
    for (int i = 0; i < HWLP_N_SLOTS; i++)
    begin
      if (match[i] && !hit)
      begin
        hit       = 1'b1;
        win_idx   = HWLP_SLOT_BITS'(i);
        win_oh[i] = 1'b1;
      end
    end
  end

  assign win_cnt   = counter_i[win_idx];
  assign win_start = start_i[win_idx];

  // Jump back unless this is the last pass
  assign hwlp_jump_o      = hit && (win_cnt > XLEN'(1));
  assign hwlp_targ_addr_o = hwlp_jump_o ? win_start : '0;

  // Count down only the winner, and only when fetch takes the PC
  assign dec_o = win_oh & {HWLP_N_SLOTS{fetch_advance_i}};

endmodule

//--- hwlp_pkg.sv
// Shared constants and types for the hardware-loop unit
// Import into every module that needs slot count, field positions or opcodes

package hwlp_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Number of loop register sets
  localparam int HWLP_N_SLOTS   = 2;
  // Slot index width, never below one bit
  localparam int HWLP_SLOT_BITS = (HWLP_N_SLOTS > 1) ? $clog2(HWLP_N_SLOTS) : 1;
  // Address and data width
  localparam int XLEN           = 32;

  // Major opcode shared by all loop setup instructions
  localparam logic [6:0] HWLP_OPCODE = 7'h7b;

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_MSB = 6;
  // Destination field, low bits carry the slot id
  localparam int RD_LSB     = 7;
  localparam int RD_MSB     = 11;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_MSB = 14;
  // Source field, doubles as short end offset for setup forms
  localparam int RS1_LSB    = 15;
  localparam int RS1_MSB    = 19;
  // I-type immediate
  localparam int IMM_I_LSB  = 20;
  localparam int IMM_I_MSB  = 31;

  ////////////////////////////////////////
  // Setup opcodes (funct3)
  ////////////////////////////////////////

  // 6 and 7 left undefined, decoder ignores them
  typedef enum logic [2:0] {
    HWLP_STARTI = 3'd0,  // start = pc_id + imm
    HWLP_ENDI   = 3'd1,  // end = pc_id + imm
    HWLP_COUNT  = 3'd2,  // count = rs1
    HWLP_COUNTI = 3'd3,  // count = zext imm
    HWLP_SETUP  = 3'd4,  // start, end, count from rs1
    HWLP_SETUPI = 3'd5   // start, end, count from imm
  } hwlp_op_e;

endpackage

//--- hwlp_setup_decoder.sv
// Decoder for the hardware-loop setup instructions
// Turns one retiring instruction into per-slot write enables and the
// start, end and count values broadcast to all loop slots

`timescale 1ns/1ps

module hwlp_setup_decoder (
  input  logic                              instr_valid_i,
  input  logic [hwlp_pkg::XLEN-1:0]         instr_rdata_i,
  input  logic [hwlp_pkg::XLEN-1:0]         pc_id_i,
  input  logic [hwlp_pkg::XLEN-1:0]         pc_if_i,
  input  logic [hwlp_pkg::XLEN-1:0]         rs1_data_i,
  output logic [hwlp_pkg::HWLP_N_SLOTS-1:0] start_we_o,
  output logic [hwlp_pkg::HWLP_N_SLOTS-1:0] end_we_o,
  output logic [hwlp_pkg::HWLP_N_SLOTS-1:0] cnt_we_o,
  output logic [hwlp_pkg::XLEN-1:0]         start_data_o,
  output logic [hwlp_pkg::XLEN-1:0]         end_data_o,
  output logic [hwlp_pkg::XLEN-1:0]         cnt_data_o
);

  import hwlp_pkg::*;

  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [4:0]                rd_field;
  logic [4:0]                rs1_field;
  logic [HWLP_SLOT_BITS-1:0] slot_id;
  hwlp_op_e                  op;

  logic [XLEN-1:0]           imm_i_sext;
  logic [XLEN-1:0]           imm_i_zext;
  logic [XLEN-1:0]           imm_z_shl;
  logic [XLEN-1:0]           addr_imm;
  logic [XLEN-1:0]           addr_z;

  logic                      op_known;
  logic                      start_sel;
  logic                      end_sel;
  logic                      cnt_sel;
  logic                      setup_form;
  logic                      cnt_from_rs1;
  logic                      instr_hit;
  logic [HWLP_N_SLOTS-1:0]   slot_oh;

  // Field split
  assign opcode    = instr_rdata_i[OPCODE_MSB:OPCODE_LSB];
  assign funct3    = instr_rdata_i[FUNCT3_MSB:FUNCT3_LSB];
  assign rd_field  = instr_rdata_i[RD_MSB:RD_LSB];
  assign rs1_field = instr_rdata_i[RS1_MSB:RS1_LSB];
  assign slot_id   = rd_field[HWLP_SLOT_BITS-1:0];
  assign op        = hwlp_op_e'(funct3);

  ////////////////////////////////////////
  // Immediates and address adders
  ////////////////////////////////////////

  assign imm_i_sext = {{(XLEN-12){instr_rdata_i[IMM_I_MSB]}},
                       instr_rdata_i[IMM_I_MSB:IMM_I_LSB]};
  assign imm_i_zext = {{(XLEN-12){1'b0}}, instr_rdata_i[IMM_I_MSB:IMM_I_LSB]};
  // rs1 field as halfword offset
  assign imm_z_shl  = {{(XLEN-6){1'b0}}, rs1_field, 1'b0};

  // Two adders, both relative to the decoded PC
  assign addr_imm = pc_id_i + imm_i_sext;
  assign addr_z   = pc_id_i + imm_z_shl;

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb
  begin
    start_sel = 1'b0;
    end_sel   = 1'b0;
    cnt_sel   = 1'b0;
    op_known  = 1'b1;
    case (op)
      HWLP_STARTI: start_sel = 1'b1;
      HWLP_ENDI:   end_sel   = 1'b1;
      HWLP_COUNT,
      HWLP_COUNTI: cnt_sel   = 1'b1;
      HWLP_SETUP,
      HWLP_SETUPI:
      begin
        start_sel = 1'b1;
        end_sel   = 1'b1;
        cnt_sel   = 1'b1;
      end
      // funct3 6 and 7
      default:     op_known  = 1'b0;
    endcase
  end

  assign setup_form   = (op == HWLP_SETUP) || (op == HWLP_SETUPI);
  assign cnt_from_rs1 = (op == HWLP_COUNT) || (op == HWLP_SETUP);

  // Only a valid, defined loop instruction writes
  assign instr_hit = instr_valid_i && (opcode == HWLP_OPCODE) && op_known;

  // Data mux, shared by every slot
  assign start_data_o = setup_form ? pc_if_i : addr_imm;
  assign end_data_o   = setup_form ? addr_z : addr_imm;
  assign cnt_data_o   = cnt_from_rs1 ? rs1_data_i : imm_i_zext;

  // Slot id to one-hot
  always_comb
  begin
    for (int i = 0; i < HWLP_N_SLOTS; i++)
    begin
      slot_oh[i] = (slot_id == HWLP_SLOT_BITS'(i));
    end
  end

  assign start_we_o = slot_oh & {HWLP_N_SLOTS{instr_hit && start_sel}};
  assign end_we_o   = slot_oh & {HWLP_N_SLOTS{instr_hit && end_sel}};
  assign cnt_we_o   = slot_oh & {HWLP_N_SLOTS{instr_hit && cnt_sel}};

endmodule

//--- hwlp_slot.sv
// One hardware-loop register set: start address, end address, counter
// Loaded by the setup decoder, counted down by the loop controller
// Instantiated once per slot from the unit top level

`timescale 1ns/1ps

module hwlp_slot (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_we_i,
  input  logic                      end_we_i,
  input  logic                      cnt_we_i,
  input  logic                      dec_i,
  input  logic [hwlp_pkg::XLEN-1:0] start_data_i,
  input  logic [hwlp_pkg::XLEN-1:0] end_data_i,
  input  logic [hwlp_pkg::XLEN-1:0] cnt_data_i,
  output logic [hwlp_pkg::XLEN-1:0] start_o,
  output logic [hwlp_pkg::XLEN-1:0] end_o,
  output logic [hwlp_pkg::XLEN-1:0] counter_o
);

  import hwlp_pkg::*;

  logic [XLEN-1:0] start_q;
  logic [XLEN-1:0] end_q;
  logic [XLEN-1:0] counter_q;

  // Loop start
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      start_q <= '0;
    else if (start_we_i)
      start_q <= start_data_i;
  end

  // Loop end, compared against fetch PC
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      end_q <= '0;
    else if (end_we_i)
      end_q <= end_data_i;
  end

  // Iteration counter
  // a new count overrides a decrement on the same edge
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      counter_q <= '0;
    end
    else if (cnt_we_i)
    begin
      counter_q <= cnt_data_i;
    end
    else if (dec_i)
    begin
      counter_q <= counter_q - 1'b1;
    end
  end

  assign start_o   = start_q;
  assign end_o     = end_q;
  assign counter_o = counter_q;

endmodule

//--- hwlp_unit.f
hwlp_pkg.sv
hwlp_setup_decoder.sv
hwlp_slot.sv
hwlp_loop_ctrl.sv
hwlp_unit.sv
tb_hwlp_unit.sv

//--- hwlp_unit.sv
// Hardware-loop unit of the decode stage, standalone
// Setup decoder feeds a bank of loop slots; the loop controller reads them
// and returns jump requests for the fetch stage

`timescale 1ns/1ps

module hwlp_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_valid_i,
  input  logic [hwlp_pkg::XLEN-1:0] instr_rdata_i,
  input  logic [hwlp_pkg::XLEN-1:0] pc_id_i,
  input  logic [hwlp_pkg::XLEN-1:0] pc_if_i,
  input  logic [hwlp_pkg::XLEN-1:0] rs1_data_i,
  input  logic                      fetch_advance_i,
  output logic                      hwlp_jump_o,
  output logic [hwlp_pkg::XLEN-1:0] hwlp_targ_addr_o
);

  import hwlp_pkg::*;

  // Decoder to slots
  logic [HWLP_N_SLOTS-1:0]           start_we;
  logic [HWLP_N_SLOTS-1:0]           end_we;
  logic [HWLP_N_SLOTS-1:0]           cnt_we;
  logic [XLEN-1:0]                   start_data;
  logic [XLEN-1:0]                   end_data;
  logic [XLEN-1:0]                   cnt_data;

  // Slots to controller and back
  logic [HWLP_N_SLOTS-1:0][XLEN-1:0] slot_start;
  logic [HWLP_N_SLOTS-1:0][XLEN-1:0] slot_end;
  logic [HWLP_N_SLOTS-1:0][XLEN-1:0] slot_cnt;
  logic [HWLP_N_SLOTS-1:0]           slot_dec;

  ////////////////////////////////////////
  // Setup decode
  ////////////////////////////////////////

  hwlp_setup_decoder setup_decoder_inst (
    .instr_valid_i ( instr_valid_i ),
    .instr_rdata_i ( instr_rdata_i ),
    .pc_id_i       ( pc_id_i       ),
    .pc_if_i       ( pc_if_i       ),
    .rs1_data_i    ( rs1_data_i    ),
    .start_we_o    ( start_we      ),
    .end_we_o      ( end_we        ),
    .cnt_we_o      ( cnt_we        ),
    .start_data_o  ( start_data    ),
    .end_data_o    ( end_data      ),
    .cnt_data_o    ( cnt_data      )
  );

  ////////////////////////////////////////
  // Loop register sets
  ////////////////////////////////////////

  for (genvar i = 0; i < HWLP_N_SLOTS; i++)
  begin : gen_slot
    hwlp_slot slot_inst (
      .clk          ( clk           ),
      .rst_n        ( rst_n         ),
      .start_we_i   ( start_we[i]   ),
      .end_we_i     ( end_we[i]     ),
      .cnt_we_i     ( cnt_we[i]     ),
      .dec_i        ( slot_dec[i]   ),
      .start_data_i ( start_data    ),
      .end_data_i   ( end_data      ),
      .cnt_data_i   ( cnt_data      ),
      .start_o      ( slot_start[i] ),
      .end_o        ( slot_end[i]   ),
      .counter_o    ( slot_cnt[i]   )
    );
  end

  // Jump decision, purely combinational on pc_if_i
  hwlp_loop_ctrl loop_ctrl_inst (
    .pc_if_i          ( pc_if_i          ),
    .fetch_advance_i  ( fetch_advance_i  ),
    .start_i          ( slot_start       ),
    .end_i            ( slot_end         ),
    .counter_i        ( slot_cnt         ),
    .dec_o            ( slot_dec         ),
    .hwlp_jump_o      ( hwlp_jump_o      ),
    .hwlp_targ_addr_o ( hwlp_targ_addr_o )
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the hardware-loop unit testbench with Verilator
# Exits nonzero when the build fails or the testbench reports a failure

cd "$(dirname "$0")" || exit 1

TOP=tb_hwlp_unit
FLIST=hwlp_unit.f
OBJ_DIR=obj_dir
LOG=sim.log

echo "Building $TOP"
verilator --binary --timing --assert \
  --top-module "$TOP" \
  -Mdir "$OBJ_DIR" \
  -f "$FLIST"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Build failed with status $build_status"
  exit 1
fi

echo "Running simulation"
"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- tb_hwlp_unit.sv
// Self-checking testbench for the hardware-loop unit
// A slot model follows every edge and predicts jump and target each cycle
// Stimulus from a seeded LFSR, built and run by run_sim.sh

`timescale 1ns/1ps

module tb_hwlp_unit;

  import hwlp_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int RST_CYCLES  = 5;
  localparam int IDLE_CYCLES = 16;
  localparam int MAX_CNT     = 5;
  localparam int HOLD_CYCLES = 4;
  // Filler and end-address cycle per pass, plus one drain cycle
  localparam int LOOP_CYCLES = 2 * (MAX_CNT + 1) + 1;
  // Worst case per test, in test order
  localparam int TEST_CYCLES = RST_CYCLES + IDLE_CYCLES
                             + 2 * (3 + LOOP_CYCLES)
                             + 2 * (1 + LOOP_CYCLES)
                             + 3 + 2 * (2 * MAX_CNT + 1)
                             + 9 + HOLD_CYCLES + 2 * LOOP_CYCLES;

  logic            clk;
  logic            rst_n;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_rdata_i;
  logic [XLEN-1:0] pc_id_i;
  logic [XLEN-1:0] pc_if_i;
  logic [XLEN-1:0] rs1_data_i;
  logic            fetch_advance_i;
  logic            hwlp_jump_o;
  logic [XLEN-1:0] hwlp_targ_addr_o;

  logic [31:0]     lfsr_state;
  // Slot model
  logic [XLEN-1:0] m_start [HWLP_N_SLOTS];
  logic [XLEN-1:0] m_end   [HWLP_N_SLOTS];
  logic [XLEN-1:0] m_cnt   [HWLP_N_SLOTS];
  int              jump_count;

  hwlp_unit hwlp_unit_inst (
    .clk              ( clk              ),
    .rst_n            ( rst_n            ),
    .instr_valid_i    ( instr_valid_i    ),
    .instr_rdata_i    ( instr_rdata_i    ),
    .pc_id_i          ( pc_id_i          ),
    .pc_if_i          ( pc_if_i          ),
    .rs1_data_i       ( rs1_data_i       ),
    .fetch_advance_i  ( fetch_advance_i  ),
    .hwlp_jump_o      ( hwlp_jump_o      ),
    .hwlp_targ_addr_o ( hwlp_targ_addr_o )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("MISMATCH at %0t ns: %s expected 0x%08h actual 0x%08h", $time, name, exp_v, act_v);
    $display("=== FAIL ===");
    $fatal(1, "output check failed");
  endtask

  task automatic abort_run(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Word-aligned address
  function automatic logic [XLEN-1:0] rand_pc();
    logic [31:0] r;
    r = rand_bits(30);
    return {r[29:0], 2'b00};
  endfunction

  function automatic logic [31:0] make_instr(input logic [6:0] opc, input logic [2:0] f3,
                                             input int slot, input logic [4:0] rs1f,
                                             input logic [11:0] imm);
    logic [4:0] rd;
    rd = 5'(slot);
    return {imm, rs1f, f3, rd, opc};
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Lowest active slot whose end is the fetch PC, -1 if none
  function automatic int find_winner();
    int w;
    w = -1;
    for (int i = HWLP_N_SLOTS - 1; i >= 0; i--)
    begin
      if (m_cnt[i] != '0 && m_end[i] == pc_if_i)
        w = i;
    end
    return w;
  endfunction

  task automatic clear_model();
    for (int i = 0; i < HWLP_N_SLOTS; i++)
    begin
      m_start[i] = '0;
      m_end[i]   = '0;
      m_cnt[i]   = '0;
    end
    jump_count = 0;
  endtask

  task automatic check_outputs();
    int              win;
    logic            exp_jump;
    logic [XLEN-1:0] exp_targ;
    win      = find_winner();
    exp_jump = 1'b0;
    exp_targ = '0;
    if (win >= 0 && m_cnt[win] > 32'd1)
    begin
      exp_jump = 1'b1;
      exp_targ = m_start[win];
    end
    assert (hwlp_jump_o === exp_jump)
      else report_mismatch("hwlp_jump_o", 32'(exp_jump), 32'(hwlp_jump_o));
    assert (hwlp_targ_addr_o === exp_targ)
      else report_mismatch("hwlp_targ_addr_o", exp_targ, hwlp_targ_addr_o);
    if (hwlp_jump_o)
      jump_count++;
  endtask

  task automatic update_model();
    int              win;
    int              slot;
    hwlp_op_e        op;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] end_z;
    win = find_winner();
    // Decrement first, a count write on this edge overrides it
    if (fetch_advance_i && win >= 0)
      m_cnt[win] = m_cnt[win] - 32'd1;
    if (instr_valid_i && instr_rdata_i[OPCODE_MSB:OPCODE_LSB] == HWLP_OPCODE
        && instr_rdata_i[FUNCT3_MSB:FUNCT3_LSB] < 3'd6)
    begin
      slot  = int'(instr_rdata_i[RD_LSB +: HWLP_SLOT_BITS]);
      op    = hwlp_op_e'(instr_rdata_i[FUNCT3_MSB:FUNCT3_LSB]);
      imm_s = {{(XLEN-12){instr_rdata_i[IMM_I_MSB]}}, instr_rdata_i[IMM_I_MSB:IMM_I_LSB]};
      imm_u = {{(XLEN-12){1'b0}}, instr_rdata_i[IMM_I_MSB:IMM_I_LSB]};
      end_z = pc_id_i + {{(XLEN-6){1'b0}}, instr_rdata_i[RS1_MSB:RS1_LSB], 1'b0};
      case (op)
        HWLP_STARTI: m_start[slot] = pc_id_i + imm_s;
        HWLP_ENDI:   m_end[slot]   = pc_id_i + imm_s;
        HWLP_COUNT:  m_cnt[slot]   = rs1_data_i;
        HWLP_COUNTI: m_cnt[slot]   = imm_u;
        HWLP_SETUP,
        HWLP_SETUPI:
        begin
          m_start[slot] = pc_if_i;
          m_end[slot]   = end_z;
          m_cnt[slot]   = (op == HWLP_SETUP) ? rs1_data_i : imm_u;
        end
        default: ;
      endcase
    end
  endtask

  // Outputs settle before the edge, inputs change only on the falling edge
  always @(posedge clk)
  begin
    if (!rst_n)
      clear_model();
    else
    begin
      check_outputs();
      update_model();
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic drive_cycle(input logic valid, input logic [31:0] instr,
                             input logic [XLEN-1:0] pc_id, input logic [XLEN-1:0] pc_if,
                             input logic [XLEN-1:0] rs1, input logic adv);
    @(negedge clk);
    instr_valid_i   = valid;
    instr_rdata_i   = instr;
    pc_id_i         = pc_id;
    pc_if_i         = pc_if;
    rs1_data_i      = rs1;
    fetch_advance_i = adv;
  endtask

  task automatic issue_setup(input hwlp_op_e op, input int slot, input logic [4:0] rs1f,
                             input logic [11:0] imm, input logic [XLEN-1:0] pc_id,
                             input logic [XLEN-1:0] rs1);
    drive_cycle(1'b1, make_instr(HWLP_OPCODE, op, slot, rs1f, imm), pc_id, rand_pc(), rs1,
                1'b0);
  endtask

  // n passes over the end address, each after a filler fetch
  task automatic run_to_end(input logic [XLEN-1:0] end_addr, input int n);
    for (int k = 0; k < n; k++)
    begin
      drive_cycle(1'b0, '0, '0, rand_pc(), '0, 1'b0);
      drive_cycle(1'b0, '0, '0, end_addr, '0, 1'b1);
    end
    drive_cycle(1'b0, '0, '0, rand_pc(), '0, 1'b0);
  endtask

  task automatic expect_jumps(input int base, input int exp_n);
    int seen;
    seen = jump_count - base;
    assert (seen == exp_n)
      else report_mismatch("hwlp_jump_o pulse count", 32'(exp_n), 32'(seen));
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic idle_after_reset();
    int base;
    base = jump_count;
    // Random instructions with valid low, random fetch strobes
    repeat (IDLE_CYCLES)
      drive_cycle(1'b0, rand_bits(32), rand_pc(), rand_pc(), rand_bits(32), 1'(rand_bits(1)));
    expect_jumps(base, 0);
  endtask

  task automatic immediate_loop(input int slot);
    logic [XLEN-1:0] pc_id;
    logic [11:0]     imm_e;
    logic [XLEN-1:0] end_addr;
    int              cnt;
    int              base;
    pc_id    = rand_pc();
    imm_e    = 12'(rand_bits(12)) & 12'hffc;
    cnt      = 2 + int'(rand_bits(2));
    end_addr = pc_id + {{(XLEN-12){imm_e[11]}}, imm_e};
    issue_setup(HWLP_STARTI, slot, 5'd0, 12'(rand_bits(12)) & 12'hffc, pc_id, '0);
    issue_setup(HWLP_ENDI, slot, 5'd0, imm_e, pc_id, '0);
    issue_setup(HWLP_COUNTI, slot, 5'd0, 12'(cnt), pc_id, '0);
    base = jump_count;
    // One extra pass shows the slot gone inactive
    run_to_end(end_addr, cnt + 1);
    expect_jumps(base, cnt - 1);
  endtask

  task automatic setup_loops();
    logic [XLEN-1:0] pc_id;
    logic [4:0]      rs1f;
    logic [XLEN-1:0] end_addr;
    int              cnt;
    int              base;
    // Register form, count from rs1
    pc_id    = rand_pc();
    rs1f     = 5'(rand_bits(5)) | 5'd1;
    cnt      = 2 + int'(rand_bits(2));
    end_addr = pc_id + {{(XLEN-6){1'b0}}, rs1f, 1'b0};
    issue_setup(HWLP_SETUP, 0, rs1f, 12'(rand_bits(12)), pc_id, 32'(cnt));
    base = jump_count;
    run_to_end(end_addr, cnt + 1);
    expect_jumps(base, cnt - 1);
    // Immediate form, rs1 data ignored
    pc_id    = rand_pc();
    rs1f     = 5'(rand_bits(5)) | 5'd1;
    cnt      = 2 + int'(rand_bits(2));
    end_addr = pc_id + {{(XLEN-6){1'b0}}, rs1f, 1'b0};
    issue_setup(HWLP_SETUPI, 1, rs1f, 12'(cnt), pc_id, rand_bits(32));
    base = jump_count;
    run_to_end(end_addr, cnt + 1);
    expect_jumps(base, cnt - 1);
  endtask

  task automatic shared_end_priority();
    logic [XLEN-1:0] pc_id;
    logic [4:0]      rs1f;
    logic [XLEN-1:0] end_addr;
    int              c0;
    int              c1;
    int              base;
    pc_id    = rand_pc();
    rs1f     = 5'(rand_bits(5)) | 5'd1;
    c0       = 2 + int'(rand_bits(2));
    c1       = 2 + int'(rand_bits(2));
    end_addr = pc_id + {{(XLEN-6){1'b0}}, rs1f, 1'b0};
    // Same end, different start taken from the fetch PC
    issue_setup(HWLP_SETUPI, 0, rs1f, 12'(c0), pc_id, '0);
    issue_setup(HWLP_SETUPI, 1, rs1f, 12'(c1), pc_id, '0);
    base = jump_count;
    // Slot 0 drains first, then slot 1
    run_to_end(end_addr, c0 + c1 + 1);
    expect_jumps(base, c0 + c1 - 2);
  endtask

  task automatic ignored_writes();
    logic [XLEN-1:0] pc_id;
    logic [11:0]     imm_e;
    logic [4:0]      rs1f;
    logic [XLEN-1:0] end_addr;
    int              base;
    pc_id    = rand_pc();
    imm_e    = 12'(rand_bits(12)) & 12'hffc;
    rs1f     = 5'(rand_bits(5)) | 5'd1;
    end_addr = pc_id + {{(XLEN-12){imm_e[11]}}, imm_e};
    issue_setup(HWLP_STARTI, 0, 5'd0, 12'(rand_bits(12)) & 12'hffc, pc_id, '0);
    issue_setup(HWLP_ENDI, 0, 5'd0, imm_e, pc_id, '0);
    issue_setup(HWLP_COUNT, 0, 5'd0, 12'd0, pc_id, 32'd3);
    // Wrong opcode, undefined funct3, valid low
    drive_cycle(1'b1, make_instr(HWLP_OPCODE ^ 7'h04, HWLP_SETUPI, 0, rs1f, 12'd9),
                pc_id, rand_pc(), 32'd9, 1'b0);
    drive_cycle(1'b1, make_instr(HWLP_OPCODE, 3'd6, 0, rs1f, 12'd9), pc_id, rand_pc(), 32'd9,
                1'b0);
    drive_cycle(1'b1, make_instr(HWLP_OPCODE, 3'd7, 0, rs1f, 12'd9), pc_id, rand_pc(), 32'd9,
                1'b0);
    drive_cycle(1'b0, make_instr(HWLP_OPCODE, HWLP_SETUPI, 0, rs1f, 12'd9), pc_id, rand_pc(),
                32'd9, 1'b0);
    base = jump_count;
    // Parked on the end, fetch stalled
    repeat (HOLD_CYCLES)
      drive_cycle(1'b0, '0, '0, end_addr, '0, 1'b0);
    run_to_end(end_addr, 4);
    expect_jumps(base, HOLD_CYCLES + 2);
    // Count write and decrement on one edge
    issue_setup(HWLP_COUNTI, 0, 5'd0, 12'd2, pc_id, '0);
    base = jump_count;
    drive_cycle(1'b1, make_instr(HWLP_OPCODE, HWLP_COUNTI, 0, 5'd0, 12'd3), pc_id, end_addr,
                '0, 1'b1);
    run_to_end(end_addr, 4);
    expect_jumps(base, 3);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial
  begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    instr_valid_i   = 1'b0;
    instr_rdata_i   = '0;
    pc_id_i         = '0;
    pc_if_i         = '0;
    rs1_data_i      = '0;
    fetch_advance_i = 1'b0;
    lfsr_state      = 32'hc5aa5935;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    idle_after_reset();
    immediate_loop(0);
    immediate_loop(1);
    setup_loops();
    shared_end_priority();
    ignored_writes();

    $display("=== PASS ===");
    $finish;
  end

  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

endmodule
